// ==== tb.f ====
src/game_pkg.sv
src/game_state_ctrl.sv
src/scroll_tracker.sv
src/wall_map.sv
src/pickup_field.sv
src/pixel_compositor.sv
src/frame_decider.sv
tb/tb_frame_decider.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_frame_decider -f tb.f --Mdir obj_dir
./obj_dir/Vtb_frame_decider

// ==== tb/tb_frame_decider.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_frame_decider;

	import game_pkg::*;

	logic clk;
	logic rst_n;
	pixel_t pix;
	logic pix_req;
	color_t color;
	logic pix_ack;
	hero_pos_t hero;
	logic frame_tick;
	logic press;
	stop_t stop;
	logic [SCORE_W-1:0] score;
	game_state_t state;

	// Reference model of the game
	logic [31:0] lfsr;
	game_state_t model_state;
	int model_scroll;
	int model_score;
	logic [NUM_COINS-1:0] model_collected;

	frame_decider u_dut (
		.clk(clk), .rst_n(rst_n), .pix(pix), .pix_req(pix_req), .color(color),
		.pix_ack(pix_ack), .hero(hero), .frame_tick(frame_tick), .press(press),
		.stop(stop), .score(score), .state(state)
	);

	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0])
			return (s >> 1) ^ 32'h80200003;
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	task automatic random_bits(input int n, output int value);
		value = 0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			value = (value << 1) | int'(lfsr[0]);
		end
	endtask

	task automatic check_equal(input string name, input int actual, input int expected);
		if (actual != expected)
		begin
			$display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, name, actual,
				expected);
			$display("** FAIL **");
			$fatal(1, "value check failed");
		end
	endtask

	function automatic logic tile_is_wall(input int r, input int c);
		if (r >= 0 && r < MAP_ROWS && c >= 0 && c < MAP_COLS)
			return TILE_MAP[r][c];
		return 1'b0;
	endfunction

	function automatic logic inside_box(input int px, input int py, input int ox, input int oy,
			input int w, input int h);
		return px >= ox && px < ox + w && py >= oy && py < oy + h;
	endfunction

	function automatic logic touches_hero(input int wx, input int wy);
		return inside_box(wx, wy, int'(hero.x), int'(hero.y), int'(HERO_W), int'(HERO_H));
	endfunction

	function automatic int predict_color(input int wx, input int wy);
		logic coin;
		coin = 1'b0;
		if (model_state == ST_TITLE)
			return int'(COLOR_TITLE);
		if (model_state == ST_END)
			return int'(COLOR_END);
		for (int i = 0; i < NUM_COINS; i++)
			if (!model_collected[i] && inside_box(wx, wy, int'(COIN_X[i]), int'(COIN_Y),
					int'(TILE_SIZE), int'(TILE_SIZE)))
				coin = 1'b1;
		if (tile_is_wall(wy / int'(TILE_SIZE), wx / int'(TILE_SIZE)))
			return int'(COLOR_WALL);
		if (touches_hero(wx, wy))
			return int'(COLOR_HERO);
		if (coin)
			return int'(COLOR_COIN);
		if (inside_box(wx, wy, int'(GOAL_X), int'(GOAL_Y), int'(TILE_SIZE), int'(TILE_SIZE)))
			return int'(COLOR_GOAL);
		return int'(COLOR_BG);
	endfunction

	function automatic stop_t predict_stop(input int hx, input int hy);
		stop_t s;
		int r;
		int c;
		r = hy / int'(TILE_SIZE);
		c = hx / int'(TILE_SIZE);
		s.down = tile_is_wall(r + 2, c) || tile_is_wall(r + 2, c + 1);
		s.left = tile_is_wall(r + 1, (hx + 1) / int'(TILE_SIZE));
		s.right = tile_is_wall(r + 1, c + 1);
		return s;
	endfunction

	// Collisions of the answered pixel, applied after the answer
	task automatic note_pickups(input int wx, input int wy);
		if (model_state == ST_PLAY && touches_hero(wx, wy))
		begin
			for (int i = 0; i < NUM_COINS; i++)
				if (!model_collected[i] && inside_box(wx, wy, int'(COIN_X[i]), int'(COIN_Y),
						int'(TILE_SIZE), int'(TILE_SIZE)))
				begin
					model_collected[i] = 1'b1;
					model_score++;
				end
			if (inside_box(wx, wy, int'(GOAL_X), int'(GOAL_Y), int'(TILE_SIZE), int'(TILE_SIZE)))
				model_state = ST_END;
		end
	endtask

	task automatic wait_for_ack(input logic level);
		int cycles;
		cycles = 0;
		while (pix_ack !== level)
		begin
			if (cycles == 20)
			begin
				$display("Timed out waiting for pix_ack to become %0b", level);
				$display("** FAIL **");
				$fatal(1, "handshake timeout");
			end
			@(posedge clk);
			#2;
			cycles++;
		end
	endtask

	// Full four-phase request of one screen pixel
	task automatic request_pixel(input int sx, input int sy);
		int wx;
		int expected;
		wx = sx + model_scroll;
		expected = predict_color(wx, sy);
		pix.x = coord_t'(sx);
		pix.y = coord_t'(sy);
		pix_req = 1'b1;
		wait_for_ack(1'b1);
		check_equal("color", int'(color), expected);
		pix_req = 1'b0;
		wait_for_ack(1'b0);
		note_pickups(wx, sy);
		check_equal("score", int'(score), model_score);
	endtask

	task automatic request_world(input int wx, input int wy);
		request_pixel(wx - model_scroll, wy);
	endtask

	task automatic random_pixels(input int count);
		int sx;
		int sy;
		for (int i = 0; i < count; i++)
		begin
			random_bits(10, sx);
			random_bits(9, sy);
			request_pixel(sx % int'(SCREEN_W), sy % 480);
		end
	endtask

	task automatic send_frame_tick(input int hx, input int hy);
		int target;
		hero.x = coord_t'(hx);
		hero.y = coord_t'(hy);
		frame_tick = 1'b1;
		@(posedge clk);
		#2;
		frame_tick = 1'b0;
		if (hx < int'(SCROLL_MARGIN))
			target = 0;
		else if (hx - int'(SCROLL_MARGIN) > int'(MAX_SCROLL))
			target = int'(MAX_SCROLL);
		else
			target = hx - int'(SCROLL_MARGIN);
		if (target > model_scroll)
			model_scroll = target;
	endtask

	task automatic after_reset_title();
		check_equal("score", int'(score), 0);
		check_equal("stop", int'(stop), 0);
		check_equal("pix_ack", int'(pix_ack), 0);
		check_equal("state", int'(state), int'(ST_TITLE));
		random_pixels(6);
		// Stop flags hold outside play
		send_frame_tick(40, 320);
		check_equal("stop", int'(stop), 0);
		// Hero over coin 0 collects nothing on the title screen
		hero.x = 11'd100;
		hero.y = 11'd280;
		request_pixel(110, 310);
		hero.x = 11'd40;
		hero.y = 11'd320;
	endtask

	task automatic play_without_scroll();
		press = 1'b1;
		@(posedge clk);
		#2;
		press = 1'b0;
		model_state = ST_PLAY;
		check_equal("state", int'(state), int'(ST_PLAY));
		request_pixel(50, 330);
		request_pixel(10, 420);
		request_pixel(120, 310);
		request_pixel(600, 250);
		random_pixels(12);
	endtask

	task automatic forward_only_scroll();
		send_frame_tick(300, 320);
		send_frame_tick(500, 320);
		send_frame_tick(700, 320);
		send_frame_tick(600, 320);
		send_frame_tick(500, 320);
		// Park the hero above the coin row
		hero.y = 11'd0;
		// Raised block at world 560 sits right at screen 140 with a scroll of 420
		request_pixel(140, 250);
		request_pixel(139, 250);
		request_pixel(0, 400);
		request_pixel(300, 100);
		random_pixels(10);
	endtask

	task automatic coin_pickup_once();
		hero.x = 11'd500;
		hero.y = 11'd280;
		request_world(510, 310);
		check_equal("score after pickup", int'(score), 1);
		request_world(510, 310);
		check_equal("score after repeat", int'(score), 1);
		hero.y = 11'd0;
		request_world(520, 320);
		check_equal("coin 4 gone", int'(color != COLOR_COIN), 1);
	endtask

	task automatic wall_stop_flags();
		int xs[5];
		int ys[5];
		xs = '{40, 1199, 1160, 320, 100};
		ys = '{320, 280, 280, 280, 1000};
		for (int i = 0; i < 5; i++)
		begin
			send_frame_tick(xs[i], ys[i]);
			check_equal("stop", int'(stop), int'(predict_stop(xs[i], ys[i])));
		end
	endtask

	task automatic goal_ends_game();
		int score_before;
		score_before = model_score;
		hero.x = 11'd980;
		hero.y = 11'd280;
		request_world(990, 290);
		check_equal("state", int'(state), int'(ST_END));
		random_pixels(8);
		check_equal("score", int'(score), score_before);
	endtask

	initial
	begin
		lfsr = 32'hc81109dd;
		rst_n = 1'b0;
		pix = '0;
		pix_req = 1'b0;
		hero.x = 11'd40;
		hero.y = 11'd320;
		frame_tick = 1'b0;
		press = 1'b0;
		model_state = ST_TITLE;
		model_scroll = 0;
		model_score = 0;
		model_collected = '0;
		repeat (5) @(posedge clk);
		#2;
		rst_n = 1'b1;
		after_reset_title();
		play_without_scroll();
		forward_only_scroll();
		coin_pickup_once();
		wall_stop_flags();
		goal_ends_game();
		$display("** PASS **");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src/frame_decider.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_decider (
	input  wire                          clk,
	input  wire                          rst_n,
	input  game_pkg::pixel_t             pix,
	input  wire                          pix_req,
	output game_pkg::color_t             color,
	output logic                         pix_ack,
	input  game_pkg::hero_pos_t          hero,
	input  wire                          frame_tick,
	input  wire                          press,
	output game_pkg::stop_t              stop,
	output logic [game_pkg::SCORE_W-1:0] score,
	output game_pkg::game_state_t        state
);

	import game_pkg::*;

	coord_t scroll;
	pixel_t world;
	logic sample;
	logic hero_hit;
	logic wall_hit;
	logic coin_hit;
	logic goal_hit;
	logic goal_touched;

	game_state_ctrl u_state (
		.clk(clk), .rst_n(rst_n), .press(press), .goal_touched(goal_touched), .state(state)
	);

	scroll_tracker u_scroll (
		.clk(clk), .rst_n(rst_n), .hero(hero), .frame_tick(frame_tick), .scroll(scroll)
	);

	wall_map u_walls (
		.clk(clk), .rst_n(rst_n), .state(state), .hero(hero), .frame_tick(frame_tick),
		.world(world), .wall_hit(wall_hit), .stop(stop)
	);

	pickup_field u_pickups (
		.clk(clk), .rst_n(rst_n), .world(world), .sample(sample), .hero_hit(hero_hit),
		.coin_hit(coin_hit), .goal_hit(goal_hit), .score(score), .goal_touched(goal_touched)
	);

	pixel_compositor u_comp (
		.clk(clk), .rst_n(rst_n), .pix(pix), .pix_req(pix_req), .pix_ack(pix_ack),
		.color(color), .state(state), .scroll(scroll), .hero(hero), .world(world),
		.sample(sample), .hero_hit(hero_hit), .wall_hit(wall_hit), .coin_hit(coin_hit),
		.goal_hit(goal_hit)
	);

endmodule

`default_nettype wire

// ==== src/pixel_compositor.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_compositor (
	input  wire                   clk,
	input  wire                   rst_n,
	input  game_pkg::pixel_t      pix,
	input  wire                   pix_req,
	output logic                  pix_ack,
	output game_pkg::color_t      color,
	input  game_pkg::game_state_t state,
	input  game_pkg::coord_t      scroll,
	input  game_pkg::hero_pos_t   hero,
	output game_pkg::pixel_t      world,
	output logic                  sample,
	output logic                  hero_hit,
	input  wire                   wall_hit,
	input  wire                   coin_hit,
	input  wire                   goal_hit
);

	import game_pkg::*;

	// High in the cycle between capture and answer
	logic looking;
	color_t color_next;

	assign sample = looking && state == ST_PLAY;
	assign hero_hit = in_box(world, hero.x, hero.y, HERO_W, HERO_H);

	always_comb
	begin
		if (state == ST_TITLE)
			color_next = COLOR_TITLE;
		else if (state == ST_END)
			color_next = COLOR_END;
		else if (wall_hit)
			color_next = COLOR_WALL;
		else if (hero_hit)
			color_next = COLOR_HERO;
		else if (coin_hit)
			color_next = COLOR_COIN;
		else if (goal_hit)
			color_next = COLOR_GOAL;
		else
			color_next = COLOR_BG;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			looking <= 1'b0;
			pix_ack <= 1'b0;
		end
		else if (looking)
		begin
			looking <= 1'b0;
			pix_ack <= 1'b1;
		end
		else if (pix_ack)
			pix_ack <= pix_req;
		else if (pix_req)
			looking <= 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (!looking && !pix_ack && pix_req)
		begin
			world.x <= pix.x + scroll;
			world.y <= pix.y;
		end
		if (looking)
			color <= color_next;
	end

endmodule

`default_nettype wire

// ==== src/pickup_field.sv ====
`timescale 1ns/1ps
`default_nettype none

module pickup_field (
	input  wire                              clk,
	input  wire                              rst_n,
	input  game_pkg::pixel_t                 world,
	input  wire                              sample,
	input  wire                              hero_hit,
	output logic                             coin_hit,
	output logic                             goal_hit,
	output logic [game_pkg::SCORE_W-1:0]     score,
	output logic                             goal_touched
);

	import game_pkg::*;

	logic [NUM_COINS-1:0] coin_in;
	logic [NUM_COINS-1:0] collected;
	logic [NUM_COINS-1:0] grab;
	logic touch;

	function automatic logic [SCORE_W-1:0] count_ones(input logic [NUM_COINS-1:0] bits);
		logic [SCORE_W-1:0] n;
		n = '0;
		for (int i = 0; i < NUM_COINS; i++)
			n = n + SCORE_W'(bits[i]);
		return n;
	endfunction

	always_comb
	begin
		for (int i = 0; i < NUM_COINS; i++)
			coin_in[i] = in_box(world, COIN_X[i], COIN_Y, TILE_SIZE, TILE_SIZE);
	end

	assign goal_hit = in_box(world, GOAL_X, GOAL_Y, TILE_SIZE, TILE_SIZE);
	assign coin_hit = |(coin_in & ~collected);

	// A collision is a pixel shared by the hero and the object
	assign touch = sample && hero_hit;
	assign grab = touch ? (coin_in & ~collected) : '0;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			collected <= '0;
			score <= '0;
			goal_touched <= 1'b0;
		end
		else
		begin
			collected <= collected | grab;
			score <= score + count_ones(grab);
			if (touch && goal_hit)
				goal_touched <= 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== src/wall_map.sv ====
`timescale 1ns/1ps
`default_nettype none

module wall_map (
	input  wire                   clk,
	input  wire                   rst_n,
	input  game_pkg::game_state_t state,
	input  game_pkg::hero_pos_t   hero,
	input  wire                   frame_tick,
	input  game_pkg::pixel_t      world,
	output logic                  wall_hit,
	output game_pkg::stop_t       stop
);

	import game_pkg::*;

	coord_t pix_row;
	coord_t pix_col;
	coord_t hero_row;
	coord_t hero_col;
	coord_t left_col;
	logic [11:0] hero_x_p1;
	stop_t stop_next;

	// Anything outside the map reads as open space
	function automatic logic tile_at(input logic [11:0] row, input logic [11:0] col);
		if (row < 12'(MAP_ROWS) && col < 12'(MAP_COLS))
			return TILE_MAP[row[3:0]][col[5:0]];
		return 1'b0;
	endfunction

	assign pix_row = world.y / TILE_SIZE;
	assign pix_col = world.x / TILE_SIZE;
	assign wall_hit = tile_at({1'b0, pix_row}, {1'b0, pix_col});

	assign hero_row = hero.y / TILE_SIZE;
	assign hero_col = hero.x / TILE_SIZE;
	assign hero_x_p1 = {1'b0, hero.x} + 12'd1;
	assign left_col = coord_t'(hero_x_p1 / 12'(TILE_SIZE));

	// Feet are two tiles below the hero's top row, the body one tile below
	always_comb
	begin
		stop_next.down = tile_at({1'b0, hero_row} + 12'd2, {1'b0, hero_col})
			|| tile_at({1'b0, hero_row} + 12'd2, {1'b0, hero_col} + 12'd1);
		stop_next.left = tile_at({1'b0, hero_row} + 12'd1, {1'b0, left_col});
		stop_next.right = tile_at({1'b0, hero_row} + 12'd1, {1'b0, hero_col} + 12'd1);
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			stop <= '0;
		else if (frame_tick && state == ST_PLAY)
			stop <= stop_next;
	end

endmodule

`default_nettype wire

// ==== src/scroll_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module scroll_tracker (
	input  wire                clk,
	input  wire                rst_n,
	input  game_pkg::hero_pos_t hero,
	input  wire                frame_tick,
	output game_pkg::coord_t    scroll
);

	import game_pkg::*;

	coord_t target;

	// Keep the hero SCROLL_MARGIN from the left edge, within the world
	always_comb
	begin
		if (hero.x < SCROLL_MARGIN)
			target = '0;
		else if (hero.x - SCROLL_MARGIN > MAX_SCROLL)
			target = MAX_SCROLL;
		else
			target = hero.x - SCROLL_MARGIN;
	end

	// Camera only moves forward
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			scroll <= '0;
		else if (frame_tick && target > scroll)
			scroll <= target;
	end

endmodule

`default_nettype wire

// ==== src/game_state_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_state_ctrl (
	input  wire                  clk,
	input  wire                  rst_n,
	input  wire                  press,
	input  wire                  goal_touched,
	output game_pkg::game_state_t state
);

	import game_pkg::*;

	game_state_t state_next;

	always_comb
	begin
		state_next = state;
		case (state)
			ST_TITLE:
			begin
				if (press)
					state_next = ST_PLAY;
			end
			ST_PLAY:
			begin
				if (goal_touched)
					state_next = ST_END;
			end
			// End screen stays up until reset
			default:
				state_next = ST_END;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= ST_TITLE;
		else
			state <= state_next;
	end

endmodule

`default_nettype wire

// ==== src/game_pkg.sv ====
`default_nettype none

package game_pkg;

	typedef logic [10:0] coord_t;
	typedef logic [5:0] color_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} pixel_t;

	// Top-left corner of the hero in world space
	typedef struct packed {
		coord_t x;
		coord_t y;
	} hero_pos_t;

	typedef struct packed {
		logic down;
		logic left;
		logic right;
	} stop_t;

	typedef enum logic [1:0] {
		ST_TITLE,
		ST_PLAY,
		ST_END
	} game_state_t;

	localparam coord_t TILE_SIZE = 11'd40;
	localparam int MAP_ROWS = 12;
	localparam int MAP_COLS = 40;

	localparam coord_t SCREEN_W = 11'd640;
	localparam coord_t WORLD_W = 11'd1600;
	localparam coord_t SCROLL_MARGIN = 11'd280;
	localparam coord_t MAX_SCROLL = WORLD_W - SCREEN_W;

	localparam coord_t HERO_W = 11'd40;
	localparam coord_t HERO_H = 11'd80;

	// Column 0 is the leftmost bit of each row
	localparam logic [0:MAP_ROWS-1][0:MAP_COLS-1] TILE_MAP = {
		40'b0000000000_0000000000_0000000000_0000000000,
		40'b0000000000_0000000000_0000000000_0000000000,
		40'b0000000000_0000000000_0000000000_0000000000,
		40'b0000000000_0000000000_0000000000_0000000000,
		40'b0000000000_0000000000_0000000000_0000000000,
		40'b0000000000_0000000000_0000000000_0000000000,
		40'b0000000000_0000110000_0000000000_0000000000,
		40'b0000000000_0000000000_0000000000_0000000000,
		40'b0000000000_0000000000_0000000000_1100000000,
		40'b0000000011_0000000000_0000000000_0000000000,
		40'b1111111111_1111111111_1111111111_1111111111,
		40'b1111111111_1111111111_1111111111_1111111111
	};

	localparam int NUM_COINS = 8;
	localparam coord_t COIN_X [NUM_COINS] = '{
		11'd100, 11'd160, 11'd200, 11'd400, 11'd500, 11'd600, 11'd700, 11'd800
	};
	localparam coord_t COIN_Y = 11'd300;

	localparam coord_t GOAL_X = 11'd980;
	localparam coord_t GOAL_Y = 11'd280;

	localparam int SCORE_W = 4;

	localparam color_t COLOR_BG = 6'd0;
	localparam color_t COLOR_TITLE = 6'd8;
	localparam color_t COLOR_END = 6'd9;
	localparam color_t COLOR_WALL = 6'd12;
	localparam color_t COLOR_HERO = 6'd20;
	localparam color_t COLOR_COIN = 6'd33;
	localparam color_t COLOR_GOAL = 6'd40;

	// Half-open box test where the far edge lies outside
	function automatic logic in_box(input pixel_t p, input coord_t ox, input coord_t oy,
			input coord_t w, input coord_t h);
		logic [11:0] x_end;
		logic [11:0] y_end;
		x_end = {1'b0, ox} + {1'b0, w};
		y_end = {1'b0, oy} + {1'b0, h};
		return (p.x >= ox) && ({1'b0, p.x} < x_end) && (p.y >= oy) && ({1'b0, p.y} < y_end);
	endfunction

endpackage

`default_nettype wire
